/* sim.f */
+incdir+.
wb_bus_pkg.sv
wb_map_pkg.sv
wb_addr_decode.sv
wb_resp_mux.sv
wb_mux.sv
tb_wb_mux.sv

/* run.sh */
#!/bin/sh
# Build and run the Wishbone mux testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    --top-module tb_wb_mux \
    -f sim.f

# Exit status of the pipe is that of tee, the log decides
./obj_dir/Vtb_wb_mux 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    echo "Run reported failure, see sim.log"
    exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
    echo "Run ended without a result line, see sim.log"
    exit 1
fi

echo "Run completed, see sim.log"

/* tb_wb_model.svh */
`ifndef TB_WB_MODEL_SVH
`define TB_WB_MODEL_SVH

// Prefix rule, compare only where the mask has ones
function automatic logic prefix_hit(
    input logic [ADDR_WIDTH-1:0] adr,                      // Master address
    input logic [ADDR_WIDTH-1:0] pfx,                      // Slave prefix
    input logic [ADDR_WIDTH-1:0] msk                       // Slave mask
);
    return (adr & msk) == (pfx & msk);
endfunction

// Lowest matching index wins, scanned from the top so the last hit stays
function automatic logic [NUM_SLAVES-1:0] expect_select(
    input logic [ADDR_WIDTH-1:0]                 adr,
    input logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] pfx,
    input logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] msk
);
    logic [NUM_SLAVES-1:0] sel;
    sel = '0;
    for (int i = NUM_SLAVES - 1; i >= 0; i--) begin
        if (prefix_hit(adr, pfx[i], msk[i])) begin
            sel    = '0;                                   // Drop the higher index
            sel[i] = 1'b1;
        end
    end
    return sel;
endfunction

// Number of slaves whose prefix covers the address
function automatic int count_hits(
    input logic [ADDR_WIDTH-1:0]                 adr,
    input logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] pfx,
    input logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] msk
);
    int hits;
    hits = 0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
        if (prefix_hit(adr, pfx[i], msk[i])) begin
            hits++;
        end
    end
    return hits;
endfunction

// Control line reaches the winner only while the master drives it
function automatic logic [NUM_SLAVES-1:0] expect_gate(
    input logic [NUM_SLAVES-1:0] sel,
    input logic                  ctrl
);
    return ctrl ? sel : '0;
endfunction

// Winner's data, zero for an empty select
function automatic logic [DATA_WIDTH-1:0] expect_read_data(
    input logic [NUM_SLAVES-1:0]                 sel,
    input logic [NUM_SLAVES-1:0][DATA_WIDTH-1:0] dat
);
    logic [DATA_WIDTH-1:0] data;
    data = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
        if (sel[i]) begin
            data = dat[i];
        end
    end
    return data;
endfunction

// Slave errors plus the miss on an active access
function automatic logic expect_err(
    input logic [NUM_SLAVES-1:0] sel,
    input logic                  cyc,
    input logic                  stb,
    input logic [NUM_SLAVES-1:0] err
);
    return (|err) | (cyc & stb & (sel == '0));
endfunction

task automatic check_value(
    input string       name,                               // Signal under test
    input logic [63:0] got,
    input logic [63:0] exp
);
    if (got !== exp) begin
        $display("FAIL %s got %h expected %h at cycle %0d", name, got, exp, cycle_count);
        $display("Simulation failed");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

`endif

/* tb_wb_mux.sv */
module tb_wb_mux;

    localparam int DATA_WIDTH   = wb_bus_pkg::DATA_WIDTH;
    localparam int ADDR_WIDTH   = wb_bus_pkg::ADDR_WIDTH;
    localparam int SEL_WIDTH    = wb_bus_pkg::SEL_WIDTH;
    localparam int NUM_SLAVES   = wb_map_pkg::NUM_SLAVES;
    localparam int IDX_WIDTH    = wb_map_pkg::SLAVE_IDX_WIDTH;
    localparam int TOTAL_CYCLES = 2000;                    // Run length
    localparam int PHASE_CYCLES = 250;                     // Cycles per address map
    localparam int HOLD_LIMIT   = 64;                      // Max wait for a response
    localparam int RESET_CYCLES = 8;

    logic                                  clk;
    logic                                  rst_i;
    logic [ADDR_WIDTH-1:0]                 wbm_adr_i;
    logic [DATA_WIDTH-1:0]                 wbm_dat_i;
    logic [DATA_WIDTH-1:0]                 wbm_dat_o;
    logic                                  wbm_we_i;
    logic [SEL_WIDTH-1:0]                  wbm_sel_i;
    logic                                  wbm_stb_i;
    logic                                  wbm_ack_o;
    logic                                  wbm_err_o;
    logic                                  wbm_rty_o;
    logic                                  wbm_cyc_i;
    logic [ADDR_WIDTH-1:0]                 wbs_adr_o;
    logic [DATA_WIDTH-1:0]                 wbs_dat_o;
    logic [SEL_WIDTH-1:0]                  wbs_sel_o;
    logic [NUM_SLAVES-1:0]                 wbs_we_o;
    logic [NUM_SLAVES-1:0]                 wbs_stb_o;
    logic [NUM_SLAVES-1:0]                 wbs_cyc_o;
    logic [NUM_SLAVES-1:0][DATA_WIDTH-1:0] wbs_dat_i;
    logic [NUM_SLAVES-1:0]                 wbs_ack_i;
    logic [NUM_SLAVES-1:0]                 wbs_err_i;
    logic [NUM_SLAVES-1:0]                 wbs_rty_i;
    logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_i;
    logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_msk_i;

    integer seed;                                          // Random state
    int     cycle_count;
    int     phase_idx;                                     // Map kind rotates per phase
    int     phase_end;
    int     access_count;
    int     hole_count;                                    // Active accesses into a hole
    int     overlap_count;                                 // Active accesses with several hits

    `include "tb_wb_model.svh"

    always #5 clk = ~clk;

    wb_mux #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .NUM_SLAVES     (NUM_SLAVES)
    ) dut0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .wbm_adr_i      (wbm_adr_i),
        .wbm_dat_i      (wbm_dat_i),
        .wbm_dat_o      (wbm_dat_o),
        .wbm_we_i       (wbm_we_i),
        .wbm_sel_i      (wbm_sel_i),
        .wbm_stb_i      (wbm_stb_i),
        .wbm_ack_o      (wbm_ack_o),
        .wbm_err_o      (wbm_err_o),
        .wbm_rty_o      (wbm_rty_o),
        .wbm_cyc_i      (wbm_cyc_i),
        .wbs_adr_o      (wbs_adr_o),
        .wbs_dat_o      (wbs_dat_o),
        .wbs_sel_o      (wbs_sel_o),
        .wbs_we_o       (wbs_we_o),
        .wbs_stb_o      (wbs_stb_o),
        .wbs_cyc_o      (wbs_cyc_o),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_ack_i      (wbs_ack_i),
        .wbs_err_i      (wbs_err_i),
        .wbs_rty_i      (wbs_rty_i),
        .wbs_addr_i     (wbs_addr_i),
        .wbs_addr_msk_i (wbs_addr_msk_i)
    );

    task automatic next_rand(output logic [31:0] r);
        r = $random(seed);
    endtask

    // Ones in the top bits of the address
    function automatic logic [ADDR_WIDTH-1:0] top_mask(input int bits);
        logic [ADDR_WIDTH-1:0] m;
        m = '0;
        for (int b = 0; b < bits; b++) begin
            m[ADDR_WIDTH-1-b] = 1'b1;
        end
        return m;
    endfunction

    // Kind 0 disjoint and full, kind 1 overlapping with catch-all, kind 2 with holes
    task automatic build_map(input int kind);
        logic [31:0] r;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            next_rand(r);
            case (kind)
                0:       wbs_addr_msk_i[i] = top_mask(IDX_WIDTH);
                1:       wbs_addr_msk_i[i] = (i == NUM_SLAVES - 1) ? '0 : top_mask(IDX_WIDTH);
                default: wbs_addr_msk_i[i] = top_mask(IDX_WIDTH + 2);
            endcase
            wbs_addr_i[i] = ADDR_WIDTH'(r);                 // Low bits are don't care
            if (kind == 0) begin
                wbs_addr_i[i][ADDR_WIDTH-1 -: IDX_WIDTH] = IDX_WIDTH'(i);  // Index in top bits
            end
        end
    endtask

    task automatic drive_request();
        logic [31:0] r;
        logic [31:0] a;
        int          k;
        next_rand(r);
        next_rand(a);
        k         = int'(r[15:8]) % NUM_SLAVES;             // Slave to aim at
        wbm_cyc_i = r[0] | r[1];                            // High three times in four
        wbm_stb_i = r[2] | r[3];
        wbm_we_i  = r[4];
        wbm_sel_i = r[16 +: SEL_WIDTH];
        if (r[5]) begin
            wbm_adr_i = (ADDR_WIDTH'(a) & ~wbs_addr_msk_i[k])
                      | (wbs_addr_i[k] & wbs_addr_msk_i[k]);  // Inside slave k
        end else begin
            wbm_adr_i = ADDR_WIDTH'(a);
        end
        next_rand(a);
        wbm_dat_i = DATA_WIDTH'(a);
    endtask

    // One response kind per cycle, so ack and err never meet
    task automatic drive_responses();
        logic [31:0]           r;
        logic [NUM_SLAVES-1:0] hit;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            next_rand(r);
            wbs_dat_i[i] = DATA_WIDTH'(r);
        end
        next_rand(r);
        hit = r[4 +: NUM_SLAVES];
        if (hit == '0) begin
            hit[int'(r[15:8]) % NUM_SLAVES] = 1'b1;         // At least one responder
        end
        wbs_ack_i = (r[1:0] == 2'd1) ? hit : '0;
        wbs_err_i = (r[1:0] == 2'd2) ? hit : '0;
        wbs_rty_i = (r[1:0] == 2'd3) ? hit : '0;
    endtask

    task automatic check_outputs();
        logic [NUM_SLAVES-1:0] exp_sel;
        logic                  active;
        exp_sel = expect_select(wbm_adr_i, wbs_addr_i, wbs_addr_msk_i);
        active  = wbm_cyc_i & wbm_stb_i;
        check_value("wbs_stb_o", 64'(wbs_stb_o), 64'(expect_gate(exp_sel, wbm_stb_i)));
        check_value("wbs_cyc_o", 64'(wbs_cyc_o), 64'(expect_gate(exp_sel, wbm_cyc_i)));
        check_value("wbs_we_o", 64'(wbs_we_o), 64'(expect_gate(exp_sel, wbm_we_i)));
        check_value("wbm_dat_o", 64'(wbm_dat_o), 64'(expect_read_data(exp_sel, wbs_dat_i)));
        check_value("wbm_ack_o", 64'(wbm_ack_o), 64'(|wbs_ack_i));
        check_value("wbm_err_o", 64'(wbm_err_o),
                    64'(expect_err(exp_sel, wbm_cyc_i, wbm_stb_i, wbs_err_i)));
        check_value("wbm_rty_o", 64'(wbm_rty_o), 64'(|wbs_rty_i));
        check_value("wbs_adr_o", 64'(wbs_adr_o), 64'(wbm_adr_i));   // Shared pass-through
        check_value("wbs_dat_o", 64'(wbs_dat_o), 64'(wbm_dat_i));
        check_value("wbs_sel_o", 64'(wbs_sel_o), 64'(wbm_sel_i));
        if (active && exp_sel == '0) begin
            hole_count++;
        end
        if (active && count_hits(wbm_adr_i, wbs_addr_i, wbs_addr_msk_i) > 1) begin
            overlap_count++;
        end
    endtask

    // Drive just after the edge, sample just before the next one
    task automatic run_cycle(input logic new_request);
        @(posedge clk);
        #1;
        if (new_request) begin
            if (cycle_count >= phase_end) begin
                build_map(phase_idx % 3);                   // Map changes between accesses
                phase_idx++;
                phase_end += PHASE_CYCLES;
            end
            drive_request();
        end
        drive_responses();
        #7;
        check_outputs();
        cycle_count++;
    endtask

    // Master holds its request until ack, err or rty comes back
    task automatic do_access();
        int   waited;
        logic done;
        run_cycle(1'b1);
        done   = !(wbm_cyc_i && wbm_stb_i) || wbm_ack_o || wbm_err_o || wbm_rty_o;
        waited = 0;
        while (!done && waited < HOLD_LIMIT) begin
            run_cycle(1'b0);
            waited++;
            done = wbm_ack_o || wbm_err_o || wbm_rty_o;
        end
        if (!done) begin
            $display("Master request got no ack, err or rty within %0d cycles", HOLD_LIMIT);
            $display("Simulation failed");
            $fatal(1, "Response timeout");
        end
    endtask

    initial begin
        seed           = 91;
        cycle_count    = 0;
        phase_idx      = 0;
        phase_end      = 0;
        access_count   = 0;
        hole_count     = 0;
        overlap_count  = 0;
        clk            = 1'b0;
        rst_i          = 1'b1;
        wbm_adr_i      = '0;
        wbm_dat_i      = '0;
        wbm_we_i       = 1'b0;
        wbm_sel_i      = '0;
        wbm_stb_i      = 1'b0;
        wbm_cyc_i      = 1'b0;
        wbs_dat_i      = '0;
        wbs_ack_i      = '0;
        wbs_err_i      = '0;
        wbs_rty_i      = '0;
        wbs_addr_i     = '0;
        wbs_addr_msk_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;
        while (cycle_count < TOTAL_CYCLES) begin
            do_access();
            access_count++;
        end
        $display("Accesses %0d, cycles %0d, holes %0d, overlaps %0d",
                 access_count, cycle_count, hole_count, overlap_count);
        if (hole_count == 0 || overlap_count == 0) begin
            $display("Random stimulus never reached an address hole or an overlap");
            $display("Simulation failed");
            $fatal(1, "Stimulus coverage incomplete");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* wb_mux.sv */
module wb_mux #(
    parameter int DATA_WIDTH = wb_bus_pkg::DATA_WIDTH,     // Data bus width in bits
    parameter int ADDR_WIDTH = wb_bus_pkg::ADDR_WIDTH,     // Address bus width in bits
    parameter int NUM_SLAVES = wb_map_pkg::NUM_SLAVES,     // Number of slave ports
    localparam int SEL_WIDTH = DATA_WIDTH / wb_bus_pkg::BYTE_WIDTH  // Byte lanes
) (
    input  logic                                  clk,             // Assertion sampling
    input  logic                                  rst_i,           // Sync reset, active high

    // Master side
    input  logic [ADDR_WIDTH-1:0]                 wbm_adr_i,       // Address in
    input  logic [DATA_WIDTH-1:0]                 wbm_dat_i,       // Write data in
    output logic [DATA_WIDTH-1:0]                 wbm_dat_o,       // Read data out
    input  logic                                  wbm_we_i,        // Write enable in
    input  logic [SEL_WIDTH-1:0]                  wbm_sel_i,       // Byte select in
    input  logic                                  wbm_stb_i,       // Strobe in
    output logic                                  wbm_ack_o,       // Ack out
    output logic                                  wbm_err_o,       // Err out
    output logic                                  wbm_rty_o,       // Retry out
    input  logic                                  wbm_cyc_i,       // Cycle in

    // Shared toward all slaves
    output logic [ADDR_WIDTH-1:0]                 wbs_adr_o,       // Address out
    output logic [DATA_WIDTH-1:0]                 wbs_dat_o,       // Write data out
    output logic [SEL_WIDTH-1:0]                  wbs_sel_o,       // Byte select out

    // Per slave
    output logic [NUM_SLAVES-1:0]                 wbs_we_o,        // Write enable out
    output logic [NUM_SLAVES-1:0]                 wbs_stb_o,       // Strobe out
    output logic [NUM_SLAVES-1:0]                 wbs_cyc_o,       // Cycle out
    input  logic [NUM_SLAVES-1:0][DATA_WIDTH-1:0] wbs_dat_i,       // Read data in
    input  logic [NUM_SLAVES-1:0]                 wbs_ack_i,       // Ack in
    input  logic [NUM_SLAVES-1:0]                 wbs_err_i,       // Err in
    input  logic [NUM_SLAVES-1:0]                 wbs_rty_i,       // Retry in

    // Address map
    input  logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_i,      // Prefix per slave
    input  logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_msk_i   // Prefix mask per slave
);

    logic [NUM_SLAVES-1:0] slave_sel;                      // Decoder winner, one-hot

    // Address, write data and lanes are the same for every slave
    assign wbs_adr_o = wbm_adr_i;
    assign wbs_dat_o = wbm_dat_i;
    assign wbs_sel_o = wbm_sel_i;

    wb_addr_decode #(
        .DATA_WIDTH     (DATA_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .NUM_SLAVES     (NUM_SLAVES)
    ) decode0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .wbm_adr_i      (wbm_adr_i),
        .wbm_we_i       (wbm_we_i),
        .wbm_stb_i      (wbm_stb_i),
        .wbm_cyc_i      (wbm_cyc_i),
        .wbs_addr_i     (wbs_addr_i),
        .wbs_addr_msk_i (wbs_addr_msk_i),
        .slave_sel_o    (slave_sel),
        .wbs_we_o       (wbs_we_o),
        .wbs_stb_o      (wbs_stb_o),
        .wbs_cyc_o      (wbs_cyc_o)
    );

    // Response path, same cycle as the request
    wb_resp_mux #(
        .DATA_WIDTH     (DATA_WIDTH),
        .NUM_SLAVES     (NUM_SLAVES)
    ) resp0 (
        .clk            (clk),
        .rst_i          (rst_i),
        .slave_sel_i    (slave_sel),
        .wbm_stb_i      (wbm_stb_i),
        .wbm_cyc_i      (wbm_cyc_i),
        .wbs_dat_i      (wbs_dat_i),
        .wbs_ack_i      (wbs_ack_i),
        .wbs_err_i      (wbs_err_i),
        .wbs_rty_i      (wbs_rty_i),
        .wbm_dat_o      (wbm_dat_o),
        .wbm_ack_o      (wbm_ack_o),
        .wbm_err_o      (wbm_err_o),
        .wbm_rty_o      (wbm_rty_o)
    );

endmodule

/* wb_resp_mux.sv */
module wb_resp_mux #(
    parameter int DATA_WIDTH = wb_bus_pkg::DATA_WIDTH,     // Data bus width in bits
    parameter int NUM_SLAVES = wb_map_pkg::NUM_SLAVES      // Number of slave ports
) (
    input  logic                                  clk,          // Assertion sampling
    input  logic                                  rst_i,        // Sync reset, active high
    input  logic [NUM_SLAVES-1:0]                 slave_sel_i,  // One-hot from decoder
    input  logic                                  wbm_stb_i,    // Master strobe
    input  logic                                  wbm_cyc_i,    // Master cycle
    input  logic [NUM_SLAVES-1:0][DATA_WIDTH-1:0] wbs_dat_i,    // Read data per slave
    input  logic [NUM_SLAVES-1:0]                 wbs_ack_i,    // Ack per slave
    input  logic [NUM_SLAVES-1:0]                 wbs_err_i,    // Err per slave
    input  logic [NUM_SLAVES-1:0]                 wbs_rty_i,    // Retry per slave
    output logic [DATA_WIDTH-1:0]                 wbm_dat_o,    // Read data to master
    output logic                                  wbm_ack_o,    // Ack to master
    output logic                                  wbm_err_o,    // Err to master
    output logic                                  wbm_rty_o     // Retry to master
);

    logic master_cycle;                                    // Active bus access
    logic select_error;                                    // Access hit no slave

    // Index of the selected slave, for messages only
    function automatic logic [wb_map_pkg::SLAVE_IDX_WIDTH-1:0] sel_index(
        input logic [NUM_SLAVES-1:0] sel
    );
        logic [wb_map_pkg::SLAVE_IDX_WIDTH-1:0] idx;
        idx = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            if (sel[i]) begin
                idx = wb_map_pkg::SLAVE_IDX_WIDTH'(i);     // Select is one-hot
            end
        end
        return idx;
    endfunction

    // Read data AND-OR mux, zero when nothing is selected
    always_comb begin
        wbm_dat_o = '0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            wbm_dat_o = wbm_dat_o | ({DATA_WIDTH{slave_sel_i[i]}} & wbs_dat_i[i]);
        end
    end

    assign master_cycle = wbm_cyc_i & wbm_stb_i;           // Cyc and stb both up
    assign select_error = master_cycle & ~|slave_sel_i;    // Address in a hole

    // Responses ORed from every slave, unselected slaves stay quiet
    assign wbm_ack_o = |wbs_ack_i;
    assign wbm_err_o = (|wbs_err_i) | select_error;        // Plus the decode miss
    assign wbm_rty_o = |wbs_rty_i;

    // A selected slave must not ack and fail the same access
    ack_err_excl_a: assert property (@(posedge clk) disable iff (rst_i)
        (|slave_sel_i) |-> !(wbm_ack_o && wbm_err_o))
        else $error("wb_resp_mux: ack and err together, slave %0d selected",
                    sel_index(slave_sel_i));

endmodule

/* wb_addr_decode.sv */
module wb_addr_decode #(
    parameter int DATA_WIDTH = wb_bus_pkg::DATA_WIDTH,     // Data bus width in bits
    parameter int ADDR_WIDTH = wb_bus_pkg::ADDR_WIDTH,     // Address bus width in bits
    parameter int NUM_SLAVES = wb_map_pkg::NUM_SLAVES      // Number of slave ports
) (
    input  logic                                  clk,             // Assertion sampling
    input  logic                                  rst_i,           // Sync reset, active high
    input  logic [ADDR_WIDTH-1:0]                 wbm_adr_i,       // Master address
    input  logic                                  wbm_we_i,        // Master write enable
    input  logic                                  wbm_stb_i,       // Master strobe
    input  logic                                  wbm_cyc_i,       // Master cycle
    input  logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_i,      // Prefix per slave
    input  logic [NUM_SLAVES-1:0][ADDR_WIDTH-1:0] wbs_addr_msk_i,  // Prefix mask per slave
    output logic [NUM_SLAVES-1:0]                 slave_sel_o,     // One-hot winner or zero
    output logic [NUM_SLAVES-1:0]                 wbs_we_o,        // Write enable per slave
    output logic [NUM_SLAVES-1:0]                 wbs_stb_o,       // Strobe per slave
    output logic [NUM_SLAVES-1:0]                 wbs_cyc_o        // Cycle per slave
);

    logic [NUM_SLAVES-1:0] match;                          // Raw prefix hits

    // Data lanes must be whole bytes for the select bus to make sense
    if (DATA_WIDTH % wb_bus_pkg::BYTE_WIDTH != 0) begin : g_bad_width
        $error("wb_addr_decode: DATA_WIDTH %0d is not a whole number of bytes", DATA_WIDTH);
    end

    // Masked prefix compare, one per slave
    always_comb begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
            match[i] = ~|((wbm_adr_i ^ wbs_addr_i[i]) & wbs_addr_msk_i[i]); // Masked bits only
        end
    end

    // Priority pick, walk up from slave 0 and keep the first hit
    always_comb begin
        logic seen;                                        // Lower index already won
        seen = 1'b0;
        for (int i = 0; i < NUM_SLAVES; i++) begin
            slave_sel_o[i] = match[i] & ~seen;             // Blocked by any lower hit
            seen           = seen | match[i];
        end
    end

    // Request gating, only the winner sees the control lines
    assign wbs_we_o  = {NUM_SLAVES{wbm_we_i}}  & slave_sel_o;  // Write enable to winner
    assign wbs_stb_o = {NUM_SLAVES{wbm_stb_i}} & slave_sel_o;  // Strobe to winner
    assign wbs_cyc_o = {NUM_SLAVES{wbm_cyc_i}} & slave_sel_o;  // Cycle to winner

    // Overlapping prefixes must still leave a single winner
    sel_onehot_a: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(slave_sel_o))
        else $error("wb_addr_decode: select %b is not one-hot for address %h",
                    slave_sel_o, wbm_adr_i);

endmodule

/* wb_map_pkg.sv */
package wb_map_pkg;

    localparam int NUM_SLAVES = 4;                         // Default slave port count

    // Index width of one slave, at least one bit
    localparam int SLAVE_IDX_WIDTH = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

endpackage

/* wb_bus_pkg.sv */
package wb_bus_pkg;

    // Byte lane size, one select bit per lane
    localparam int BYTE_WIDTH = 8;

    localparam int DATA_WIDTH = 32;                        // Default data bus width
    localparam int ADDR_WIDTH = 32;                        // Default address bus width

    // Byte select width follows the data width
    localparam int SEL_WIDTH = DATA_WIDTH / BYTE_WIDTH;    // 4 lanes for 32 bits

endpackage
